//--- source/cache_pkg.sv
package cache_pkg;

  // geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int OFFSET_W   = 6;
  localparam int INDEX_W    = 5;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAYS       = 2;
  localparam int WAY_W      = $clog2(WAYS);
  localparam int SETS       = 1 << INDEX_W;
  localparam int BEATS      = 8;
  localparam int BEAT_W     = $clog2(BEATS);
  localparam int WORD_OFF_W = $clog2(DATA_W / 8);

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word,
    size_double
  } size_e;

  typedef enum logic [2:0] {
    tag_none,
    tag_set_dirty,
    tag_fill,
    tag_clean,
    tag_invalidate_all
  } tag_op_e;

  typedef enum logic [2:0] {
    st_idle,
    st_fence_scan,
    st_wb_addr,
    st_wb_data,
    st_rf_addr,
    st_rf_data
  } state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    size_e             size;
    logic [DATA_W-1:0] wdata;
  } cpu_req_t;

  // bus bursts are always BEATS beats of DATA_W, incrementing
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
  } mem_req_t;

  typedef struct packed {
    tag_op_e            op;
    logic [WAY_W-1:0]   way;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
  } tag_cmd_t;

  typedef struct packed {
    logic                  we;
    logic [WAY_W-1:0]      way;
    logic [INDEX_W-1:0]    index;
    logic [BEAT_W-1:0]     beat;
    logic [WORD_OFF_W-1:0] byte_off;
    size_e                 size;
    logic [DATA_W-1:0]     wdata;
  } data_port_t;

endpackage

//--- source/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store #(
  parameter int WAYS = cache_pkg::WAYS
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [cache_pkg::ADDR_W-1:0]  lookup_addr_i,
  output logic                          hit_o,
  output logic [cache_pkg::WAY_W-1:0]   hit_way_o,
  output logic [cache_pkg::WAY_W-1:0]   victim_way_o,
  input  logic [cache_pkg::WAY_W-1:0]   probe_way_i,
  input  logic [cache_pkg::INDEX_W-1:0] probe_index_i,
  output logic                          probe_dirty_o,
  output logic [cache_pkg::TAG_W-1:0]   probe_tag_o,
  input  cache_pkg::tag_cmd_t           cmd_i
);

  logic [cache_pkg::TAG_W-1:0]   tag_q   [WAYS][cache_pkg::SETS];
  logic [WAYS-1:0]               valid_q [cache_pkg::SETS];
  logic [WAYS-1:0]               dirty_q [cache_pkg::SETS];
  logic [cache_pkg::WAY_W-1:0]   victim_q;
  logic [cache_pkg::TAG_W-1:0]   lookup_tag;
  logic [cache_pkg::INDEX_W-1:0] lookup_index;
  logic [WAYS-1:0]               match;

  assign lookup_tag   = lookup_addr_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign lookup_index = lookup_addr_i[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];

  // compare every way of the addressed set
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      match[w] = valid_q[lookup_index][w] && (tag_q[w][lookup_index] == lookup_tag);
      if (match[w]) begin
        hit_way_o = cache_pkg::WAY_W'(w);
      end
    end
  end

  assign hit_o = |match;

  // dirty kept even when invalid, so an evicted line still writes back
  assign probe_dirty_o = dirty_q[probe_index_i][probe_way_i];
  assign probe_tag_o   = tag_q[probe_way_i][probe_index_i];

  // free-running pseudo random victim
  always_ff @(posedge clk) begin
    if (rst) begin
      victim_q <= '0;
    end else if (victim_q == cache_pkg::WAY_W'(WAYS - 1)) begin
      victim_q <= '0;
    end else begin
      victim_q <= victim_q + 1'b1;
    end
  end

  assign victim_way_o = victim_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < cache_pkg::SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end else begin
      case (cmd_i.op)
        cache_pkg::tag_set_dirty: begin
          dirty_q[cmd_i.index][cmd_i.way] <= 1'b1;
        end
        cache_pkg::tag_fill: begin
          valid_q[cmd_i.index][cmd_i.way] <= 1'b1;
          dirty_q[cmd_i.index][cmd_i.way] <= 1'b0;
        end
        cache_pkg::tag_clean: begin
          dirty_q[cmd_i.index][cmd_i.way] <= 1'b0;
        end
        cache_pkg::tag_invalidate_all: begin
          for (int s = 0; s < cache_pkg::SETS; s++) begin
            valid_q[s] <= '0;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_i.op == cache_pkg::tag_fill) begin
      tag_q[cmd_i.way][cmd_i.index] <= cmd_i.tag;
    end
  end

endmodule

//--- source/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array #(
  parameter int WAYS = cache_pkg::WAYS
) (
  input  logic                         clk,
  input  cache_pkg::data_port_t        port_i,
  output logic [cache_pkg::DATA_W-1:0] rdata_o,
  output logic [cache_pkg::DATA_W-1:0] word_o
);

  localparam int BYTES = cache_pkg::DATA_W / 8;

  logic [cache_pkg::DATA_W-1:0]     mem_q [WAYS][cache_pkg::SETS][cache_pkg::BEATS];
  logic [cache_pkg::DATA_W-1:0]     word_q;
  logic [cache_pkg::WORD_OFF_W-1:0] off_q;
  cache_pkg::size_e                 size_q;
  logic [BYTES-1:0]                 byte_en;
  logic [BYTES-1:0]                 rd_lanes;
  logic [cache_pkg::DATA_W-1:0]     wdata_sh;
  logic [cache_pkg::DATA_W-1:0]     rd_shifted;

  // low lanes covered by an access of this size
  function automatic logic [BYTES-1:0] lane_mask(cache_pkg::size_e size);
    int nbytes;
    nbytes = 1 << size;
    return BYTES'((1 << nbytes) - 1);
  endfunction

  assign byte_en  = lane_mask(port_i.size) << port_i.byte_off;
  assign wdata_sh = port_i.wdata << {port_i.byte_off, 3'b000};

  always_ff @(posedge clk) begin
    if (port_i.we) begin
      for (int b = 0; b < BYTES; b++) begin
        if (byte_en[b]) begin
          mem_q[port_i.way][port_i.index][port_i.beat][b*8 +: 8] <= wdata_sh[b*8 +: 8];
        end
      end
    end
  end

  // synchronous read, offset and size follow the word
  always_ff @(posedge clk) begin
    word_q <= mem_q[port_i.way][port_i.index][port_i.beat];
    off_q  <= port_i.byte_off;
    size_q <= port_i.size;
  end

  always_comb begin
    rd_shifted = word_q >> {off_q, 3'b000};
    rd_lanes   = lane_mask(size_q);
    for (int b = 0; b < BYTES; b++) begin
      rdata_o[b*8 +: 8] = rd_lanes[b] ? rd_shifted[b*8 +: 8] : 8'h00;
    end
  end

  // raw word for writeback beats
  assign word_o = word_q;

endmodule

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int WAYS = cache_pkg::WAYS
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req_valid_i,
  input  cache_pkg::cpu_req_t           req_i,
  output logic                          stall_o,
  input  logic                          fence_i,
  input  logic                          fence_ifetch_i,
  output logic                          fence_busy_o,
  input  logic                          hit_i,
  input  logic [cache_pkg::WAY_W-1:0]   hit_way_i,
  input  logic [cache_pkg::WAY_W-1:0]   victim_way_i,
  output logic [cache_pkg::WAY_W-1:0]   probe_way_o,
  output logic [cache_pkg::INDEX_W-1:0] probe_index_o,
  input  logic                          probe_dirty_i,
  input  logic [cache_pkg::TAG_W-1:0]   probe_tag_i,
  output cache_pkg::tag_cmd_t           tag_cmd_o,
  output cache_pkg::data_port_t         data_port_o,
  input  logic [cache_pkg::DATA_W-1:0]  word_i,
  output logic                          mem_addr_valid_o,
  input  logic                          mem_addr_ready_i,
  output cache_pkg::mem_req_t           mem_req_o,
  output logic                          mem_wvalid_o,
  input  logic                          mem_wready_i,
  output logic [cache_pkg::DATA_W-1:0]  mem_wdata_o,
  input  logic                          mem_rvalid_i,
  output logic                          mem_rready_o,
  input  logic [cache_pkg::DATA_W-1:0]  mem_rdata_i
);

  cache_pkg::state_e             state_q;
  logic                          fence_q;
  logic [cache_pkg::WAY_W-1:0]   way_q;
  logic [cache_pkg::INDEX_W-1:0] index_q;
  logic [cache_pkg::BEAT_W-1:0]  beat_q;
  logic [cache_pkg::WAY_W-1:0]   scan_way_q;
  logic [cache_pkg::INDEX_W-1:0] scan_index_q;
  cache_pkg::mem_req_t           mem_req_q;
  logic [cache_pkg::TAG_W-1:0]   req_tag;
  logic [cache_pkg::INDEX_W-1:0] req_index;
  logic                          miss;
  logic                          start_fence;
  logic                          start_miss;
  logic                          scan_last;
  logic                          aw_fire;
  logic                          w_fire;
  logic                          r_fire;
  logic                          last_beat;

  function automatic logic [cache_pkg::ADDR_W-1:0] line_addr(
    logic [cache_pkg::TAG_W-1:0]   tag,
    logic [cache_pkg::INDEX_W-1:0] index
  );
    return {tag, index, {cache_pkg::OFFSET_W{1'b0}}};
  endfunction

  assign req_tag     = req_i.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign req_index   = req_i.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign miss        = req_valid_i && !hit_i;
  assign start_fence = (state_q == cache_pkg::st_idle) && fence_i && !fence_ifetch_i;
  assign start_miss  = (state_q == cache_pkg::st_idle) && miss && !start_fence;
  assign scan_last   = (scan_way_q == cache_pkg::WAY_W'(WAYS - 1)) && (&scan_index_q);
  assign aw_fire     = mem_addr_valid_o && mem_addr_ready_i;
  assign w_fire      = mem_wvalid_o && mem_wready_i;
  assign r_fire      = mem_rvalid_i && mem_rready_o;
  assign last_beat   = beat_q == cache_pkg::BEAT_W'(cache_pkg::BEATS - 1);

  assign stall_o      = (state_q != cache_pkg::st_idle) || miss;
  assign fence_busy_o = fence_q;

  assign mem_addr_valid_o = state_q inside {cache_pkg::st_wb_addr, cache_pkg::st_rf_addr};
  assign mem_wvalid_o     = state_q == cache_pkg::st_wb_data;
  assign mem_rready_o     = state_q == cache_pkg::st_rf_data;
  assign mem_req_o        = mem_req_q;
  // word of the current beat, re-read while the bus stalls
  assign mem_wdata_o      = word_i;

  always_comb begin
    case (state_q)
      cache_pkg::st_idle: begin
        probe_way_o   = victim_way_i;
        probe_index_o = req_index;
      end
      cache_pkg::st_fence_scan: begin
        probe_way_o   = scan_way_q;
        probe_index_o = scan_index_q;
      end
      default: begin
        probe_way_o   = way_q;
        probe_index_o = index_q;
      end
    endcase
  end

  always_comb begin
    tag_cmd_o = '{op: cache_pkg::tag_none, way: way_q, index: index_q, tag: req_tag};
    case (state_q)
      cache_pkg::st_idle: begin
        if (fence_i && fence_ifetch_i) begin
          tag_cmd_o.op = cache_pkg::tag_invalidate_all;
        end else if (req_valid_i && hit_i && req_i.we) begin
          tag_cmd_o.op    = cache_pkg::tag_set_dirty;
          tag_cmd_o.way   = hit_way_i;
          tag_cmd_o.index = req_index;
        end
      end
      cache_pkg::st_wb_data: begin
        if (w_fire && last_beat && fence_q) begin
          tag_cmd_o.op = cache_pkg::tag_clean;
        end
      end
      cache_pkg::st_rf_data: begin
        if (r_fire && last_beat) begin
          tag_cmd_o.op = cache_pkg::tag_fill;
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    data_port_o = '{we: 1'b0, way: way_q, index: index_q, beat: beat_q, byte_off: '0,
                    size: cache_pkg::size_double, wdata: mem_rdata_i};
    case (state_q)
      cache_pkg::st_idle: begin
        data_port_o.we       = req_valid_i && hit_i && req_i.we;
        data_port_o.way      = hit_way_i;
        data_port_o.index    = req_index;
        data_port_o.beat     = req_i.addr[cache_pkg::WORD_OFF_W +: cache_pkg::BEAT_W];
        data_port_o.byte_off = req_i.addr[cache_pkg::WORD_OFF_W-1:0];
        data_port_o.size     = req_i.size;
        data_port_o.wdata    = req_i.wdata;
      end
      cache_pkg::st_wb_addr: begin
        data_port_o.beat = '0;
      end
      cache_pkg::st_wb_data: begin
        // read ahead once the current beat is taken
        data_port_o.beat = beat_q + cache_pkg::BEAT_W'(w_fire);
      end
      cache_pkg::st_rf_data: begin
        data_port_o.we = r_fire;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= cache_pkg::st_idle;
      fence_q      <= 1'b0;
      way_q        <= '0;
      index_q      <= '0;
      beat_q       <= '0;
      scan_way_q   <= '0;
      scan_index_q <= '0;
    end else begin
      case (state_q)
        cache_pkg::st_idle: begin
          if (start_fence) begin
            fence_q      <= 1'b1;
            scan_way_q   <= '0;
            scan_index_q <= '0;
            state_q      <= cache_pkg::st_fence_scan;
          end else if (start_miss) begin
            way_q   <= victim_way_i;
            index_q <= req_index;
            beat_q  <= '0;
            state_q <= probe_dirty_i ? cache_pkg::st_wb_addr : cache_pkg::st_rf_addr;
          end
        end
        cache_pkg::st_fence_scan: begin
          if (probe_dirty_i) begin
            way_q   <= scan_way_q;
            index_q <= scan_index_q;
            beat_q  <= '0;
            state_q <= cache_pkg::st_wb_addr;
          end else if (scan_last) begin
            fence_q <= 1'b0;
            state_q <= cache_pkg::st_idle;
          end else begin
            scan_index_q <= scan_index_q + 1'b1;
            if (&scan_index_q) begin
              scan_way_q <= scan_way_q + 1'b1;
            end
          end
        end
        cache_pkg::st_wb_addr: begin
          if (aw_fire) begin
            state_q <= cache_pkg::st_wb_data;
          end
        end
        cache_pkg::st_wb_data: begin
          if (w_fire) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              // fence rescans the same entry, now clean
              state_q <= fence_q ? cache_pkg::st_fence_scan : cache_pkg::st_rf_addr;
            end
          end
        end
        cache_pkg::st_rf_addr: begin
          if (aw_fire) begin
            state_q <= cache_pkg::st_rf_data;
          end
        end
        cache_pkg::st_rf_data: begin
          if (r_fire) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= cache_pkg::st_idle;
            end
          end
        end
        default: begin
          state_q <= cache_pkg::st_idle;
        end
      endcase
    end
  end

  // burst address, loaded as each address phase is entered
  always_ff @(posedge clk) begin
    if (start_miss) begin
      if (probe_dirty_i) begin
        mem_req_q <= '{addr: line_addr(probe_tag_i, req_index), we: 1'b1};
      end else begin
        mem_req_q <= '{addr: line_addr(req_tag, req_index), we: 1'b0};
      end
    end else if (state_q == cache_pkg::st_fence_scan && probe_dirty_i) begin
      mem_req_q <= '{addr: line_addr(probe_tag_i, scan_index_q), we: 1'b1};
    end else if (state_q == cache_pkg::st_wb_data && w_fire && last_beat && !fence_q) begin
      mem_req_q <= '{addr: line_addr(req_tag, index_q), we: 1'b0};
    end
  end

endmodule

//--- source/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
  parameter int WAYS = cache_pkg::WAYS
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req_valid_i,
  input  cache_pkg::cpu_req_t         req_i,
  output logic                        stall_o,
  output logic [cache_pkg::DATA_W-1:0] rdata_o,
  input  logic                        fence_i,
  input  logic                        fence_ifetch_i,
  output logic                        fence_busy_o,
  output logic                        mem_addr_valid_o,
  input  logic                        mem_addr_ready_i,
  output cache_pkg::mem_req_t         mem_req_o,
  output logic                        mem_wvalid_o,
  input  logic                        mem_wready_i,
  output logic [cache_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic                        mem_rvalid_i,
  output logic                        mem_rready_o,
  input  logic [cache_pkg::DATA_W-1:0] mem_rdata_i
);

  logic                          hit;
  logic [cache_pkg::WAY_W-1:0]   hit_way;
  logic [cache_pkg::WAY_W-1:0]   victim_way;
  logic [cache_pkg::WAY_W-1:0]   probe_way;
  logic [cache_pkg::INDEX_W-1:0] probe_index;
  logic                          probe_dirty;
  logic [cache_pkg::TAG_W-1:0]   probe_tag;
  cache_pkg::tag_cmd_t           tag_cmd;
  cache_pkg::data_port_t         data_port;
  logic [cache_pkg::DATA_W-1:0]  word;

  cache_ctrl #(
    .WAYS(WAYS)
  ) u_cache_ctrl (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .stall_o         (stall_o),
    .fence_i         (fence_i),
    .fence_ifetch_i  (fence_ifetch_i),
    .fence_busy_o    (fence_busy_o),
    .hit_i           (hit),
    .hit_way_i       (hit_way),
    .victim_way_i    (victim_way),
    .probe_way_o     (probe_way),
    .probe_index_o   (probe_index),
    .probe_dirty_i   (probe_dirty),
    .probe_tag_i     (probe_tag),
    .tag_cmd_o       (tag_cmd),
    .data_port_o     (data_port),
    .word_i          (word),
    .mem_addr_valid_o(mem_addr_valid_o),
    .mem_addr_ready_i(mem_addr_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_wvalid_o    (mem_wvalid_o),
    .mem_wready_i    (mem_wready_i),
    .mem_wdata_o     (mem_wdata_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rready_o    (mem_rready_o),
    .mem_rdata_i     (mem_rdata_i)
  );

  cache_tag_store #(
    .WAYS(WAYS)
  ) u_cache_tag_store (
    .clk          (clk),
    .rst          (rst),
    .lookup_addr_i(req_i.addr),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .probe_way_i  (probe_way),
    .probe_index_i(probe_index),
    .probe_dirty_o(probe_dirty),
    .probe_tag_o  (probe_tag),
    .cmd_i        (tag_cmd)
  );

  cache_data_array #(
    .WAYS(WAYS)
  ) u_cache_data_array (
    .clk    (clk),
    .port_i (data_port),
    .rdata_o(rdata_o),
    .word_o (word)
  );

endmodule

//--- testbench/cache_assert.sv
`timescale 1ns/1ps

module cache_assert (
  input logic                         clk,
  input logic                         rst,
  input logic                         addr_valid_i,
  input logic                         addr_ready_i,
  input cache_pkg::mem_req_t          mem_req_i,
  input logic                         wvalid_i,
  input logic                         wready_i,
  input logic [cache_pkg::DATA_W-1:0] wdata_i,
  input logic                         rready_i,
  input logic                         stall_i,
  input logic                         fence_busy_i
);

  // address phase held until taken
  addr_hold: assert property (@(posedge clk) disable iff (rst)
    addr_valid_i && !addr_ready_i |=> addr_valid_i && $stable(mem_req_i))
    else $error("burst address dropped or changed before ready");

  wdata_hold: assert property (@(posedge clk) disable iff (rst)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
    else $error("write beat dropped or changed before ready");

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> !addr_valid_i && !wvalid_i && !rready_i)
    else $error("bus active right after reset");

  fence_stalls: assert property (@(posedge clk) disable iff (rst)
    fence_busy_i |-> stall_i)
    else $error("fence busy without stall");

endmodule

bind cache_ctrl cache_assert u_cache_assert (
  .clk         (clk),
  .rst         (rst),
  .addr_valid_i(mem_addr_valid_o),
  .addr_ready_i(mem_addr_ready_i),
  .mem_req_i   (mem_req_o),
  .wvalid_i    (mem_wvalid_o),
  .wready_i    (mem_wready_i),
  .wdata_i     (mem_wdata_o),
  .rready_i    (mem_rready_o),
  .stall_i     (stall_o),
  .fence_busy_i(fence_busy_o)
);

//--- testbench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

  localparam int ACCESS_TIMEOUT = 500;
  localparam int FENCE_TIMEOUT  = 5000;
  localparam int ROWS           = 33;

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_dfence,
    op_ifence
  } op_e;

  typedef struct packed {
    op_e              op;
    logic [31:0]      addr;
    cache_pkg::size_e size;
    logic [63:0]      wdata;
    logic             check;
  } row_t;

  logic                clk;
  logic                rst              = 1'b1;
  logic                req_valid_i      = 1'b0;
  cache_pkg::cpu_req_t req_i            = '0;
  logic                fence_i          = 1'b0;
  logic                fence_ifetch_i   = 1'b0;
  logic                mem_addr_ready_i = 1'b0;
  logic                mem_wready_i     = 1'b0;
  logic                mem_rvalid_i     = 1'b0;
  logic [63:0]         mem_rdata_i      = '0;
  logic                stall_o;
  logic [63:0]         rdata_o;
  logic                fence_busy_o;
  logic                mem_addr_valid_o;
  cache_pkg::mem_req_t mem_req_o;
  logic                mem_wvalid_o;
  logic [63:0]         mem_wdata_o;
  logic                mem_rready_o;

  logic [7:0]  shadow_bytes [logic [31:0]];
  logic [63:0] mem_words    [logic [31:0]];
  logic [31:0] lfsr_q      = 32'h1e5c;
  logic [31:0] burst_addr  = '0;
  logic        rd_active   = 1'b0;
  logic        wr_active   = 1'b0;
  logic        timed_out   = 1'b0;
  int          beat_cnt    = 0;
  int          error_count = 0;
  int          bus_errors  = 0;
  int          check_count = 0;
  int          burst_count = 0;
  int          wb_bursts   = 0;
  // line of the previous access
  logic [25:0] prev_line    = '0;
  logic        prev_valid   = 1'b0;
  logic        after_ifence = 1'b0;

  // index 0 holds lines 1000, 2000, 3000 and 4000 in only two ways
  row_t stim [ROWS] = '{
    '{op_read,   32'h0000_1000, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_1000, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_write,  32'h0000_1009, cache_pkg::size_byte,   64'hab,                 1'b0},
    '{op_write,  32'h0000_100a, cache_pkg::size_half,   64'hbeef,               1'b0},
    '{op_write,  32'h0000_100c, cache_pkg::size_word,   64'h1234_5678,          1'b0},
    '{op_write,  32'h0000_1010, cache_pkg::size_double, 64'h0123_4567_89ab_cdef, 1'b0},
    '{op_read,   32'h0000_1008, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_100a, cache_pkg::size_half,   64'h0,                  1'b1},
    '{op_read,   32'h0000_100c, cache_pkg::size_word,   64'h0,                  1'b1},
    '{op_read,   32'h0000_1011, cache_pkg::size_byte,   64'h0,                  1'b1},
    '{op_read,   32'h0000_1014, cache_pkg::size_word,   64'h0,                  1'b1},
    '{op_write,  32'h0000_2000, cache_pkg::size_double, 64'hdead_beef_cafe_f00d, 1'b0},
    '{op_write,  32'h0000_3006, cache_pkg::size_half,   64'h5a5a,               1'b0},
    '{op_write,  32'h0000_2004, cache_pkg::size_word,   64'h0bad_f00d,          1'b0},
    '{op_read,   32'h0000_1008, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_3000, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_2000, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_write,  32'h0000_4010, cache_pkg::size_byte,   64'h77,                 1'b0},
    '{op_read,   32'h0000_1010, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_3006, cache_pkg::size_half,   64'h0,                  1'b1},
    '{op_write,  32'h0000_1040, cache_pkg::size_word,   64'hfeed_face,          1'b0},
    '{op_read,   32'h0000_1044, cache_pkg::size_word,   64'h0,                  1'b1},
    '{op_dfence, 32'h0,         cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_2004, cache_pkg::size_word,   64'h0,                  1'b1},
    '{op_ifence, 32'h0,         cache_pkg::size_double, 64'h0,                  1'b0},
    '{op_read,   32'h0000_2000, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_1008, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_3000, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_4010, cache_pkg::size_byte,   64'h0,                  1'b1},
    '{op_read,   32'h0000_1040, cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_write,  32'h0000_3008, cache_pkg::size_byte,   64'hc3,                 1'b0},
    '{op_dfence, 32'h0,         cache_pkg::size_double, 64'h0,                  1'b1},
    '{op_read,   32'h0000_3008, cache_pkg::size_double, 64'h0,                  1'b1}
  };

  cache_top u_cache_top (
    .clk             (clk),
    .rst             (rst),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .stall_o         (stall_o),
    .rdata_o         (rdata_o),
    .fence_i         (fence_i),
    .fence_ifetch_i  (fence_ifetch_i),
    .fence_busy_o    (fence_busy_o),
    .mem_addr_valid_o(mem_addr_valid_o),
    .mem_addr_ready_i(mem_addr_ready_i),
    .mem_req_o       (mem_req_o),
    .mem_wvalid_o    (mem_wvalid_o),
    .mem_wready_i    (mem_wready_i),
    .mem_wdata_o     (mem_wdata_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rready_o    (mem_rready_o),
    .mem_rdata_i     (mem_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois form, one step per bit
  function automatic logic next_random_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) begin
      lfsr_q = lfsr_q ^ 32'ha300_0000;
    end
    return out;
  endfunction

  // initial memory: address above, inverted address below
  function automatic logic [63:0] rule_word(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {base, ~base};
  endfunction

  function automatic logic [63:0] mem_word(input logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    if (mem_words.exists(base)) begin
      return mem_words[base];
    end
    return rule_word(base);
  endfunction

  function automatic logic [7:0] expected_byte(input logic [31:0] addr);
    logic [63:0] word;
    if (shadow_bytes.exists(addr)) begin
      return shadow_bytes[addr];
    end
    word = rule_word(addr);
    return word[{addr[2:0], 3'b000} +: 8];
  endfunction

  // memory model, random stalls on every handshake
  always @(posedge clk) begin
    if (rst) begin
      mem_addr_ready_i <= 1'b0;
      mem_wready_i     <= 1'b0;
      mem_rvalid_i     <= 1'b0;
      mem_rdata_i      <= '0;
      rd_active = 1'b0;
      wr_active = 1'b0;
      beat_cnt  = 0;
    end else begin
      if (mem_addr_valid_o && mem_addr_ready_i) begin
        assert (!rd_active && !wr_active) else begin
          bus_errors++;
          $display("burst at %h started before the previous burst had eight beats",
                   mem_req_o.addr);
        end
        assert (mem_req_o.addr[5:0] == 6'h00) else begin
          bus_errors++;
          $display("[ERROR] t=%0t mem_req_o.addr expected %h got %h", $time,
                   {mem_req_o.addr[31:6], 6'h00}, mem_req_o.addr);
        end
        burst_count++;
        burst_addr = mem_req_o.addr;
        beat_cnt   = 0;
        wr_active  = mem_req_o.we;
        rd_active  = !mem_req_o.we;
      end
      if (mem_wvalid_o && mem_wready_i) begin
        assert (wr_active) else begin
          bus_errors++;
          $display("write beat seen outside a write burst at t=%0t", $time);
        end
        mem_words[burst_addr + 32'(beat_cnt * 8)] = mem_wdata_o;
        beat_cnt++;
        if (beat_cnt == cache_pkg::BEATS) begin
          wr_active = 1'b0;
          wb_bursts++;
        end
      end
      if (mem_rvalid_i && mem_rready_o) begin
        beat_cnt++;
        if (beat_cnt == cache_pkg::BEATS) begin
          rd_active = 1'b0;
        end
      end
      mem_addr_ready_i <= next_random_bit();
      mem_wready_i     <= next_random_bit();
      if (rd_active) begin
        mem_rvalid_i <= next_random_bit();
      end else begin
        mem_rvalid_i <= 1'b0;
      end
      mem_rdata_i <= mem_word(burst_addr + 32'(beat_cnt * 8));
    end
  end

  task automatic do_access(input row_t row);
    int          waited;
    int          nbytes;
    logic [63:0] expected;
    nbytes = 1 << row.size;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= '{addr: row.addr, we: row.op == op_write, size: row.size,
                     wdata: row.wdata};
    waited = 0;
    @(negedge clk);
    // the line used last is still resident
    if (prev_valid && row.addr[31:6] == prev_line) begin
      check_count++;
      assert (!stall_o) else begin
        error_count++;
        $display("[ERROR] t=%0t stall_o at %h expected 0 got 1", $time, row.addr);
      end
    // no line stays valid over an instruction fence
    end else if (after_ifence) begin
      check_count++;
      assert (stall_o) else begin
        error_count++;
        $display("[ERROR] t=%0t stall_o at %h expected 1 got 0", $time, row.addr);
      end
    end
    prev_line    = row.addr[31:6];
    prev_valid   = 1'b1;
    after_ifence = 1'b0;
    // a miss keeps stall_o high until the refill is done
    while (stall_o && waited < ACCESS_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (stall_o) begin
      timed_out = 1'b1;
      error_count++;
      $display("stall_o still high after %0d cycles for address %h", waited, row.addr);
      return;
    end
    @(posedge clk);
    req_valid_i <= 1'b0;
    if (row.op == op_write) begin
      for (int i = 0; i < nbytes; i++) begin
        shadow_bytes[row.addr + 32'(i)] = row.wdata[i*8 +: 8];
      end
    end else if (row.check) begin
      expected = '0;
      for (int i = 0; i < nbytes; i++) begin
        expected[i*8 +: 8] = expected_byte(row.addr + 32'(i));
      end
      @(negedge clk);
      check_count++;
      assert (rdata_o == expected) else begin
        error_count++;
        $display("[ERROR] t=%0t rdata_o at %h expected %h got %h", $time, row.addr,
                 expected, rdata_o);
      end
    end
  endtask

  task automatic compare_memory();
    logic [31:0] addr;
    logic [63:0] word;
    if (shadow_bytes.first(addr)) begin
      do begin
        word = mem_word(addr);
        check_count++;
        assert (word[{addr[2:0], 3'b000} +: 8] == shadow_bytes[addr]) else begin
          error_count++;
          $display("[ERROR] t=%0t memory byte %h expected %h got %h", $time, addr,
                   shadow_bytes[addr], word[{addr[2:0], 3'b000} +: 8]);
        end
      end while (shadow_bytes.next(addr));
    end
  endtask

  task automatic run_fence(input logic ifetch, input logic check);
    int waited;
    @(posedge clk);
    fence_i        <= 1'b1;
    fence_ifetch_i <= ifetch;
    @(posedge clk);
    fence_i        <= 1'b0;
    fence_ifetch_i <= 1'b0;
    @(negedge clk);
    check_count++;
    if (ifetch) begin
      assert (!stall_o) else begin
        error_count++;
        $display("[ERROR] t=%0t stall_o expected 0 got 1", $time);
      end
      prev_valid   = 1'b0;
      after_ifence = 1'b1;
      return;
    end
    assert (fence_busy_o) else begin
      error_count++;
      $display("[ERROR] t=%0t fence_busy_o expected 1 got 0", $time);
    end
    waited = 0;
    while (fence_busy_o && waited < FENCE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (fence_busy_o) begin
      timed_out = 1'b1;
      error_count++;
      $display("data fence still busy after %0d cycles", waited);
    end else if (check) begin
      compare_memory();
    end
  endtask

  initial begin
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < ROWS && !timed_out; r++) begin
      case (stim[r].op)
        op_read, op_write: do_access(stim[r]);
        op_dfence:         run_fence(1'b0, stim[r].check);
        default:           run_fence(1'b1, stim[r].check);
      endcase
    end
    assert (timed_out || (!rd_active && !wr_active)) else begin
      error_count++;
      $display("a memory burst was left unfinished");
    end
    assert (timed_out || wb_bursts > 0) else begin
      error_count++;
      $display("no writeback burst was seen on the bus");
    end
    error_count += bus_errors;
    $display("errors %0d, checks %0d, bursts %0d, writebacks %0d", error_count,
             check_count, burst_count, wb_bursts);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
source/cache_pkg.sv
source/cache_tag_store.sv
source/cache_data_array.sv
source/cache_ctrl.sv
source/cache_top.sv
testbench/cache_assert.sv
testbench/cache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cache_tb -f sim.f -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
